//--- hdl/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

  // Payload width of one FIFO entry
  localparam int WIDTH = 8;

  // Register stages in each direction of the link
  localparam int PROP_DELAY = 3;

  // Entries needed to cover one full credit round trip:
  // sender link register, forward propagation, FIFO write and read,
  // reverse propagation, credit register, plus one spare
  localparam int DEPTH = 1 + PROP_DELAY + 1 + PROP_DELAY + 1 + 1;

  // Pointer width, indexes 0 .. DEPTH-1
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Count width, must hold the value DEPTH itself
  localparam int COUNT_W = $clog2(DEPTH + 1);

  // Last valid pointer value before wrap
  localparam int LAST_ADDR = DEPTH - 1;

endpackage

//--- hdl/credit_link_pkg.sv
package credit_link_pkg;

  // Startup state of either end of the link
  // LINK_RESET holds reset status asserted toward the far end
  // LINK_INIT waits for or hands out the initial credit
  // LINK_ACTIVE is normal data transfer
  typedef enum logic [1:0] {
    LINK_RESET  = 2'd0,
    LINK_INIT   = 2'd1,
    LINK_ACTIVE = 2'd2
  } link_state_e;

  // Sender credit saturates at the receiver storage size
  localparam int MAX_CREDIT = fifo_cfg_pkg::DEPTH;

  // Credits handed out by the receiver after reset
  localparam int INIT_CREDIT = fifo_cfg_pkg::DEPTH;

endpackage

//--- hdl/credit_sender.sv
`timescale 1ns/100ps

module credit_sender (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               push_valid,
  output logic                               push_ready,
  input  logic [fifo_cfg_pkg::WIDTH-1:0]     push_data,
  output logic                               sender_in_reset,
  input  logic                               receiver_in_reset,
  input  logic                               link_credit,
  output logic                               link_valid,
  output logic [fifo_cfg_pkg::WIDTH-1:0]     link_data,
  output logic [fifo_cfg_pkg::COUNT_W-1:0]   credit_count
);

  credit_link_pkg::link_state_e state;
  logic                         send;
  logic                         credit_full;

  // Only accept when the link is up and one credit is in hand
  assign push_ready  = (state == credit_link_pkg::LINK_ACTIVE) && (credit_count != '0);
  assign send        = push_valid && push_ready;
  assign credit_full = (credit_count ==
                        (fifo_cfg_pkg::COUNT_W)'(credit_link_pkg::MAX_CREDIT));

  assign sender_in_reset = (state == credit_link_pkg::LINK_RESET);

  // Link bring-up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= credit_link_pkg::LINK_RESET;
    end else begin
      unique case (state)
        credit_link_pkg::LINK_RESET: begin
          state <= credit_link_pkg::LINK_INIT;
        end
        credit_link_pkg::LINK_INIT: begin
          // Receiver status arrives through the reverse delay line
          if (!receiver_in_reset) begin
            state <= credit_link_pkg::LINK_ACTIVE;
          end
        end
        credit_link_pkg::LINK_ACTIVE: begin
          state <= credit_link_pkg::LINK_ACTIVE;
        end
        default: begin
          state <= credit_link_pkg::LINK_RESET;
        end
      endcase
    end
  end

  // Credit counter, returned pulse and send in one cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_count <= '0;
    end else if (link_credit && !send) begin
      if (!credit_full) begin
        credit_count <= credit_count + 1'b1;
      end
    end else if (send && !link_credit) begin
      credit_count <= credit_count - 1'b1;
    end
  end

  // Outgoing strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= send;
    end
  end

  // Outgoing payload, only meaningful with link_valid
  always_ff @(posedge clk) begin
    if (send) begin
      link_data <= push_data;
    end
  end

endmodule

//--- hdl/link_delay.sv
`timescale 1ns/100ps

module link_delay #(
  parameter int                NUM_STAGES = 1,
  parameter int                DATA_W     = 1,
  parameter logic [DATA_W-1:0] RESET_VAL  = '0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] in_bits,
  output logic [DATA_W-1:0] out_bits
);

  // Stage 0 is nearest the input
  logic [NUM_STAGES-1:0][DATA_W-1:0] stages;

  // Reset value lets status bits read as in reset until the pipe fills
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_STAGES; i++) begin
        stages[i] <= RESET_VAL;
      end
    end else begin
      stages[0] <= in_bits;
      for (int i = 1; i < NUM_STAGES; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign out_bits = stages[NUM_STAGES-1];

endmodule

//--- hdl/fifo_push_credit_ctrl.sv
`timescale 1ns/100ps

module fifo_push_credit_ctrl (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               link_valid,
  input  logic [fifo_cfg_pkg::WIDTH-1:0]     link_data,
  input  logic                               sender_in_reset,
  output logic                               link_credit,
  output logic                               receiver_in_reset,
  output logic                               wr_en,
  output logic [fifo_cfg_pkg::ADDR_W-1:0]    wr_addr,
  output logic [fifo_cfg_pkg::WIDTH-1:0]     wr_data,
  output logic [fifo_cfg_pkg::ADDR_W-1:0]    rd_addr,
  input  logic [fifo_cfg_pkg::WIDTH-1:0]     rd_data,
  output logic                               pop_valid,
  input  logic                               pop_ready,
  output logic [fifo_cfg_pkg::WIDTH-1:0]     pop_data,
  output logic                               empty,
  output logic                               full,
  output logic [fifo_cfg_pkg::COUNT_W-1:0]   items
);

  credit_link_pkg::link_state_e        state;
  logic [fifo_cfg_pkg::ADDR_W-1:0]     wr_ptr;
  logic [fifo_cfg_pkg::ADDR_W-1:0]     rd_ptr;
  logic [fifo_cfg_pkg::COUNT_W-1:0]    ram_count;
  logic [fifo_cfg_pkg::COUNT_W-1:0]    init_count;
  logic                                rd_issue;
  logic                                rd_pending;
  logic                                pop_fire;

  function automatic logic [fifo_cfg_pkg::ADDR_W-1:0] ptr_inc(
    input logic [fifo_cfg_pkg::ADDR_W-1:0] ptr
  );
    if (ptr == (fifo_cfg_pkg::ADDR_W)'(fifo_cfg_pkg::LAST_ADDR)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Credit flow guarantees room, every strobe is written
  assign wr_en   = link_valid;
  assign wr_addr = wr_ptr;
  assign wr_data = link_data;
  assign rd_addr = rd_ptr;

  assign pop_fire = pop_valid && pop_ready;

  // Read when the pop stage is free by the time the data lands
  assign rd_issue = (ram_count != '0) && !rd_pending && (!pop_valid || pop_ready);

  assign empty = (items == '0);
  assign full  = (items == (fifo_cfg_pkg::COUNT_W)'(fifo_cfg_pkg::DEPTH));

  assign receiver_in_reset = (state == credit_link_pkg::LINK_RESET);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      rd_pending <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_issue) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      rd_pending <= rd_issue;
    end
  end

  // ram_count covers unread RAM entries, items adds the read and pop stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_count <= '0;
      items     <= '0;
    end else begin
      if (wr_en && !rd_issue) begin
        ram_count <= ram_count + 1'b1;
      end else if (!wr_en && rd_issue) begin
        ram_count <= ram_count - 1'b1;
      end
      if (wr_en && !pop_fire) begin
        items <= items + 1'b1;
      end else if (!wr_en && pop_fire) begin
        items <= items - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_valid <= 1'b0;
    end else if (rd_pending) begin
      pop_valid <= 1'b1;
    end else if (pop_fire) begin
      pop_valid <= 1'b0;
    end
  end

  // Held while stalled since no new read lands until the stage frees
  always_ff @(posedge clk) begin
    if (rd_pending) begin
      pop_data <= rd_data;
    end
  end

  // Receiver bring-up and credit return
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= credit_link_pkg::LINK_RESET;
      init_count  <= '0;
      link_credit <= 1'b0;
    end else begin
      link_credit <= 1'b0;
      unique case (state)
        credit_link_pkg::LINK_RESET: begin
          if (!sender_in_reset) begin
            state <= credit_link_pkg::LINK_INIT;
          end
        end
        credit_link_pkg::LINK_INIT: begin
          // One initial credit per cycle
          link_credit <= 1'b1;
          init_count  <= init_count + 1'b1;
          if (init_count ==
              (fifo_cfg_pkg::COUNT_W)'(credit_link_pkg::INIT_CREDIT - 1)) begin
            state <= credit_link_pkg::LINK_ACTIVE;
          end
        end
        credit_link_pkg::LINK_ACTIVE: begin
          link_credit <= pop_fire;
        end
        default: begin
          state <= credit_link_pkg::LINK_RESET;
        end
      endcase
    end
  end

endmodule

//--- hdl/fifo_flop_ram.sv
`timescale 1ns/100ps

module fifo_flop_ram (
  input  logic                            clk,
  input  logic                            wr_en,
  input  logic [fifo_cfg_pkg::ADDR_W-1:0] wr_addr,
  input  logic [fifo_cfg_pkg::WIDTH-1:0]  wr_data,
  input  logic [fifo_cfg_pkg::ADDR_W-1:0] rd_addr,
  output logic [fifo_cfg_pkg::WIDTH-1:0]  rd_data
);

  logic [fifo_cfg_pkg::WIDTH-1:0] mem [fifo_cfg_pkg::DEPTH];

  // Single write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, data valid one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hdl/credit_fifo_top.sv
`timescale 1ns/100ps

module credit_fifo_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             push_valid,
  output logic                             push_ready,
  input  logic [fifo_cfg_pkg::WIDTH-1:0]   push_data,
  output logic                             pop_valid,
  input  logic                             pop_ready,
  output logic [fifo_cfg_pkg::WIDTH-1:0]   pop_data,
  output logic                             empty,
  output logic                             full,
  output logic [fifo_cfg_pkg::COUNT_W-1:0] items,
  output logic [fifo_cfg_pkg::COUNT_W-1:0] sender_credit
);

  // Sender side of the link
  logic                            snd_link_valid;
  logic [fifo_cfg_pkg::WIDTH-1:0]  snd_link_data;
  logic                            snd_in_reset;
  logic                            snd_link_credit;
  logic                            snd_receiver_in_reset;

  // Receiver side of the link
  logic                            rcv_link_valid;
  logic [fifo_cfg_pkg::WIDTH-1:0]  rcv_link_data;
  logic                            rcv_sender_in_reset;
  logic                            rcv_link_credit;
  logic                            rcv_in_reset;

  // RAM port
  logic                            wr_en;
  logic [fifo_cfg_pkg::ADDR_W-1:0] wr_addr;
  logic [fifo_cfg_pkg::WIDTH-1:0]  wr_data;
  logic [fifo_cfg_pkg::ADDR_W-1:0] rd_addr;
  logic [fifo_cfg_pkg::WIDTH-1:0]  rd_data;

  credit_sender sender_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_valid        (push_valid),
    .push_ready        (push_ready),
    .push_data         (push_data),
    .sender_in_reset   (snd_in_reset),
    .receiver_in_reset (snd_receiver_in_reset),
    .link_credit       (snd_link_credit),
    .link_valid        (snd_link_valid),
    .link_data         (snd_link_data),
    .credit_count      (sender_credit)
  );

  // Forward path, reset status bit in the LSB comes up asserted
  link_delay #(
    .NUM_STAGES (fifo_cfg_pkg::PROP_DELAY),
    .DATA_W     (fifo_cfg_pkg::WIDTH + 2),
    .RESET_VAL  ({1'b0, {fifo_cfg_pkg::WIDTH{1'b0}}, 1'b1})
  ) fwd_delay_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_bits  ({snd_link_valid, snd_link_data, snd_in_reset}),
    .out_bits ({rcv_link_valid, rcv_link_data, rcv_sender_in_reset})
  );

  // Reverse path carries credit and receiver status
  link_delay #(
    .NUM_STAGES (fifo_cfg_pkg::PROP_DELAY),
    .DATA_W     (2),
    .RESET_VAL  (2'b01)
  ) rev_delay_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_bits  ({rcv_link_credit, rcv_in_reset}),
    .out_bits ({snd_link_credit, snd_receiver_in_reset})
  );

  fifo_push_credit_ctrl ctrl_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .link_valid        (rcv_link_valid),
    .link_data         (rcv_link_data),
    .sender_in_reset   (rcv_sender_in_reset),
    .link_credit       (rcv_link_credit),
    .receiver_in_reset (rcv_in_reset),
    .wr_en             (wr_en),
    .wr_addr           (wr_addr),
    .wr_data           (wr_data),
    .rd_addr           (rd_addr),
    .rd_data           (rd_data),
    .pop_valid         (pop_valid),
    .pop_ready         (pop_ready),
    .pop_data          (pop_data),
    .empty             (empty),
    .full              (full),
    .items             (items)
  );

  fifo_flop_ram ram_i (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- tb/credit_fifo_assert.sv
`timescale 1ns/100ps

module credit_fifo_assert (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             link_valid,
  input logic                             link_credit,
  input logic                             full,
  input logic                             empty,
  input logic [fifo_cfg_pkg::COUNT_W-1:0] sender_credit,
  input logic                             pop_valid,
  input logic                             pop_ready,
  input logic [fifo_cfg_pkg::WIDTH-1:0]   pop_data
);

  // Credit rule leaves room for every strobe reaching the FIFO
  no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    link_valid |-> !full)
    else $error("link_valid arrived while the FIFO was full");

  // Saturation in the sender would hide a surplus returned credit
  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    link_credit |-> int'(sender_credit) < credit_link_pkg::MAX_CREDIT)
    else $error("credit returned while the sender already held the maximum");

  // Stalled pop stage holds its item
  pop_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
    else $error("pop data changed or dropped while stalled");

  pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid |-> !empty)
    else $error("pop_valid high while the FIFO reports empty");

endmodule

bind credit_fifo_top credit_fifo_assert assert_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .link_valid    (rcv_link_valid),
  .link_credit   (snd_link_credit),
  .full          (full),
  .empty         (empty),
  .sender_credit (sender_credit),
  .pop_valid     (pop_valid),
  .pop_ready     (pop_ready),
  .pop_data      (pop_data)
);

//--- tb/credit_fifo_tb.sv
`timescale 1ns/100ps

module credit_fifo_tb;

  localparam int CLK_PERIOD = 40;
  localparam int DEPTH      = fifo_cfg_pkg::DEPTH;
  localparam int WIDTH      = fifo_cfg_pkg::WIDTH;
  localparam int COUNT_W    = fifo_cfg_pkg::COUNT_W;

  // Roughly 400 items at up to 10 cycles each, plus startup
  localparam int WATCHDOG_CYCLES = 400 * 10 + 1000;

  // Credit round trip with some margin
  localparam int CREDIT_WAIT = 4 * fifo_cfg_pkg::PROP_DELAY + 8;

  logic               clk;
  logic               rst_n;
  logic               push_valid;
  logic               push_ready;
  logic [WIDTH-1:0]   push_data;
  logic               pop_valid;
  logic               pop_ready;
  logic [WIDTH-1:0]   pop_data;
  logic               empty;
  logic               full;
  logic [COUNT_W-1:0] items;
  logic [COUNT_W-1:0] sender_credit;

  // Scoreboard state
  logic [WIDTH-1:0] exp_q[$];
  string            cur_test;
  int               fail_count;
  int               pop_count;
  bit               full_seen;
  bit               pushes_done;

  credit_fifo_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .push_data     (push_data),
    .pop_valid     (pop_valid),
    .pop_ready     (pop_ready),
    .pop_data      (pop_data),
    .empty         (empty),
    .full          (full),
    .items         (items),
    .sender_credit (sender_credit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run();
    fail_count++;
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_equal(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("[FAIL] %s %s: expected %0d actual %0d", cur_test, what, expected, actual);
      stop_run();
    end
  endtask

  // Sampled on the edge, before the DUT registers update
  always @(posedge clk) begin
    if (rst_n) begin
      if (push_valid && push_ready) begin
        exp_q.push_back(push_data);
      end
      if (pop_valid && pop_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("ERROR: %s saw a pop while no pushed item was outstanding", cur_test);
          stop_run();
        end
        check_equal("pop_data", int'(exp_q[0]), int'(pop_data));
        void'(exp_q.pop_front());
        pop_count++;
      end
      if (full) begin
        full_seen = 1'b1;
      end
      assert (int'(items) <= DEPTH) else begin
        $display("ERROR: %s saw the item count go above the FIFO depth", cur_test);
        stop_run();
      end
    end
  end

  task automatic push_value(input logic [WIDTH-1:0] data);
    bit taken;
    push_valid = 1'b1;
    push_data  = data;
    taken      = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = push_ready;
      #2;
    end
    push_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_credit_restored();
    int n;
    n = 0;
    while (int'(sender_credit) != DEPTH && n < CREDIT_WAIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    check_equal("sender_credit", DEPTH, int'(sender_credit));
  endtask

  task automatic test_init_credit();
    cur_test = "test_init_credit";
    while (int'(sender_credit) != DEPTH) begin
      @(posedge clk);
      #2;
    end
    check_equal("push_ready", 1, int'(push_ready));
    check_equal("empty", 1, int'(empty));
  endtask

  task automatic test_single();
    cur_test  = "test_single";
    pop_ready = 1'b1;
    pop_count = 0;
    push_value(8'ha5);
    wait_drained();
    check_equal("pops", 1, pop_count);
    check_equal("empty", 1, int'(empty));
  endtask

  task automatic test_stream();
    cur_test  = "test_stream";
    pop_ready = 1'b1;
    pop_count = 0;
    full_seen = 1'b0;
    repeat (100) push_value(WIDTH'($urandom));
    wait_drained();
    check_equal("pops", 100, pop_count);
    check_equal("full_seen", 0, int'(full_seen));
    wait_credit_restored();
  endtask

  task automatic test_backpressure();
    int accepted;
    bit taken;
    cur_test   = "test_backpressure";
    pop_ready  = 1'b0;
    pop_count  = 0;
    accepted   = 0;
    push_valid = 1'b1;
    push_data  = WIDTH'($urandom);
    // Keep offering data well past the point where credit runs out
    repeat (4 * DEPTH) begin
      @(posedge clk);
      taken = push_ready;
      #2;
      if (taken) begin
        accepted++;
        push_data = WIDTH'($urandom);
      end
    end
    push_valid = 1'b0;
    check_equal("accepted", DEPTH, accepted);
    check_equal("push_ready", 0, int'(push_ready));
    check_equal("full", 1, int'(full));
    check_equal("items", DEPTH, int'(items));
    pop_ready = 1'b1;
    wait_drained();
    check_equal("pops", DEPTH, pop_count);
    check_equal("empty", 1, int'(empty));
    wait_credit_restored();
  endtask

  task automatic test_random_stall();
    cur_test    = "test_random_stall";
    pop_count   = 0;
    pushes_done = 1'b0;
    fork
      begin
        repeat (200) push_value(WIDTH'($urandom));
        pushes_done = 1'b1;
      end
      begin
        while (!pushes_done || exp_q.size() != 0) begin
          @(posedge clk);
          #2;
          pop_ready = 1'($urandom);
        end
      end
    join
    pop_ready = 1'b1;
    check_equal("pops", 200, pop_count);
    wait_credit_restored();
  endtask

  initial begin
    void'($urandom(32'h8100));
    rst_n       = 1'b0;
    push_valid  = 1'b0;
    push_data   = '0;
    pop_ready   = 1'b0;
    fail_count  = 0;
    pop_count   = 0;
    full_seen   = 1'b0;
    pushes_done = 1'b0;
    cur_test    = "reset";
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_init_credit();
    test_single();
    test_stream();
    test_backpressure();
    test_random_stall();
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- compile.f
hdl/fifo_cfg_pkg.sv
hdl/credit_link_pkg.sv
hdl/credit_sender.sv
hdl/link_delay.sv
hdl/fifo_push_credit_ctrl.sv
hdl/fifo_flop_ram.sv
hdl/credit_fifo_top.sv
tb/credit_fifo_assert.sv
tb/credit_fifo_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module credit_fifo_tb \
  -f compile.f -o credit_fifo_sim || { echo "Build failed"; exit 1; }
./obj_dir/credit_fifo_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "Result: pass" && exit 0 || { echo "Result: fail"; exit 1; }
